// ==== design/pitaya_defines.svh ====
// widths, channel count, register word addresses and reset values
// for the analog data path and its calibration register block

`ifndef PITAYA_DEFINES_SVH
`define PITAYA_DEFINES_SVH

// channels per direction
`define PITAYA_CHN   2

// data path widths
`define SAMPLE_W     14
`define GAIN_W       16
`define ADC_PIN_W    16

// gain is fixed point, 14 fraction bits, unity at 2**14
`define GAIN_FRAC    14
`define GAIN_UNITY   16'h4000

// wishbone word address and data
`define WB_ADR_W     4
`define WB_DAT_W     32

// register map, word addresses
`define REG_LOOP     4'h0
`define REG_ADC_MUL0 4'h1
`define REG_ADC_SUM0 4'h2
`define REG_ADC_MUL1 4'h3
`define REG_ADC_SUM1 4'h4
`define REG_DAC_MUL0 4'h5
`define REG_DAC_SUM0 4'h6
`define REG_DAC_MUL1 4'h7
`define REG_DAC_SUM1 4'h8

`endif

// ==== design/pitaya_pkg.sv ====
// shared vector types of the analog data path
// samples, calibration values, converter words and wishbone fields

`include "pitaya_defines.svh"

package pitaya_pkg;

  //////////////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////////////

  // calibrated or raw sample, two's complement
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // raw word from the adc pins, data in the upper bits
  typedef logic [`ADC_PIN_W-1:0] adc_pin_t;

  // dac code, inverted offset binary
  typedef logic [`SAMPLE_W-1:0] dac_code_t;

  //////////////////////////////////////////////////////////////////////
  // calibration
  //////////////////////////////////////////////////////////////////////

  // gain, signed fixed point with GAIN_FRAC fraction bits
  typedef logic signed [`GAIN_W-1:0] gain_t;

  // offset, same scale as a sample
  typedef logic signed [`SAMPLE_W-1:0] offset_t;

  //////////////////////////////////////////////////////////////////////
  // wishbone
  //////////////////////////////////////////////////////////////////////

  typedef logic [`WB_ADR_W-1:0] wb_adr_t;
  typedef logic [`WB_DAT_W-1:0] wb_dat_t;

endpackage

// ==== design/calib_cfg_if.sv ====
// calibration settings and loopback flag
// driven by the register block, read by the channel logic

`timescale 1ns/10ps
`include "pitaya_defines.svh"

interface calib_cfg_if;

  // adc side gain and offset, one per channel
  pitaya_pkg::gain_t   [`PITAYA_CHN-1:0] adc_mul;
  pitaya_pkg::offset_t [`PITAYA_CHN-1:0] adc_sum;
  // dac side gain and offset, one per channel
  pitaya_pkg::gain_t   [`PITAYA_CHN-1:0] dac_mul;
  pitaya_pkg::offset_t [`PITAYA_CHN-1:0] dac_sum;
  // dac samples replace adc samples when set
  logic                                  digital_loop;

  // register block side
  modport regs (output adc_mul, adc_sum, dac_mul, dac_sum, digital_loop);

  // channel logic side
  modport chan (input adc_mul, adc_sum, dac_mul, dac_sum, digital_loop);

endinterface

// ==== design/calib_regs.sv ====
// wishbone classic slave for the calibration registers
// loopback flag plus gain and offset per channel and direction

`timescale 1ns/10ps
`include "pitaya_defines.svh"

module calib_regs (
  input  logic                adc_clk,
  input  logic                top_rst,
  // wishbone classic slave
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  pitaya_pkg::wb_adr_t wb_adr_i,
  input  pitaya_pkg::wb_dat_t wb_dat_i,
  output pitaya_pkg::wb_dat_t wb_dat_o,
  output logic                wb_ack_o,
  // settings to the channel logic
  calib_cfg_if.regs           cfg
);

  // sign extension widths for readback
  localparam int MUL_EXT = `WB_DAT_W - `GAIN_W;
  localparam int SUM_EXT = `WB_DAT_W - `SAMPLE_W;

  logic                                  loop_r;
  pitaya_pkg::gain_t   [`PITAYA_CHN-1:0] adc_mul_r;
  pitaya_pkg::offset_t [`PITAYA_CHN-1:0] adc_sum_r;
  pitaya_pkg::gain_t   [`PITAYA_CHN-1:0] dac_mul_r;
  pitaya_pkg::offset_t [`PITAYA_CHN-1:0] dac_sum_r;
  logic                                  wb_req;
  pitaya_pkg::wb_dat_t                   rd_dat;

  ////////////////////////////////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////////////////////////////////

  // new request, blocked in the cycle right after an ack
  assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  // single cycle ack
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_req;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // register writes
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      loop_r    <= 1'b0;
      adc_mul_r <= {`PITAYA_CHN{`GAIN_UNITY}};
      adc_sum_r <= '0;
      dac_mul_r <= {`PITAYA_CHN{`GAIN_UNITY}};
      dac_sum_r <= '0;
    end else if (wb_req && wb_we_i) begin
      // low data bits that fit each register, unmapped ignored
      case (wb_adr_i)
        `REG_LOOP:     loop_r       <= wb_dat_i[0];
        `REG_ADC_MUL0: adc_mul_r[0] <= wb_dat_i[`GAIN_W-1:0];
        `REG_ADC_SUM0: adc_sum_r[0] <= wb_dat_i[`SAMPLE_W-1:0];
        `REG_ADC_MUL1: adc_mul_r[1] <= wb_dat_i[`GAIN_W-1:0];
        `REG_ADC_SUM1: adc_sum_r[1] <= wb_dat_i[`SAMPLE_W-1:0];
        `REG_DAC_MUL0: dac_mul_r[0] <= wb_dat_i[`GAIN_W-1:0];
        `REG_DAC_SUM0: dac_sum_r[0] <= wb_dat_i[`SAMPLE_W-1:0];
        `REG_DAC_MUL1: dac_mul_r[1] <= wb_dat_i[`GAIN_W-1:0];
        `REG_DAC_SUM1: dac_sum_r[1] <= wb_dat_i[`SAMPLE_W-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////////////

  // gain and offset sign extended, flag zero extended
  always_comb begin
    rd_dat = '0;
    case (wb_adr_i)
      `REG_LOOP:     rd_dat = {{(`WB_DAT_W-1){1'b0}}, loop_r};
      `REG_ADC_MUL0: rd_dat = {{MUL_EXT{adc_mul_r[0][`GAIN_W-1]}}, adc_mul_r[0]};
      `REG_ADC_SUM0: rd_dat = {{SUM_EXT{adc_sum_r[0][`SAMPLE_W-1]}}, adc_sum_r[0]};
      `REG_ADC_MUL1: rd_dat = {{MUL_EXT{adc_mul_r[1][`GAIN_W-1]}}, adc_mul_r[1]};
      `REG_ADC_SUM1: rd_dat = {{SUM_EXT{adc_sum_r[1][`SAMPLE_W-1]}}, adc_sum_r[1]};
      `REG_DAC_MUL0: rd_dat = {{MUL_EXT{dac_mul_r[0][`GAIN_W-1]}}, dac_mul_r[0]};
      `REG_DAC_SUM0: rd_dat = {{SUM_EXT{dac_sum_r[0][`SAMPLE_W-1]}}, dac_sum_r[0]};
      `REG_DAC_MUL1: rd_dat = {{MUL_EXT{dac_mul_r[1][`GAIN_W-1]}}, dac_mul_r[1]};
      `REG_DAC_SUM1: rd_dat = {{SUM_EXT{dac_sum_r[1][`SAMPLE_W-1]}}, dac_sum_r[1]};
      default:       rd_dat = '0;
    endcase
  end

  // data presented together with ack
  always_ff @(posedge adc_clk) begin
    if (wb_req) begin
      wb_dat_o <= rd_dat;
    end
  end

  // settings out
  assign cfg.digital_loop = loop_r;
  assign cfg.adc_mul      = adc_mul_r;
  assign cfg.adc_sum      = adc_sum_r;
  assign cfg.dac_mul      = dac_mul_r;
  assign cfg.dac_sum      = dac_sum_r;

endmodule

// ==== design/gain_offset.sv ====
// calibration stage, two pipeline registers
// multiply by gain, shift by fraction bits, add offset, saturate

`timescale 1ns/10ps
`include "pitaya_defines.svh"

module gain_offset (
  input  logic                adc_clk,
  input  logic                top_rst,
  // input stream
  input  pitaya_pkg::sample_t smp_i,
  input  logic                vld_i,
  // calibration
  input  pitaya_pkg::gain_t   mul_i,
  input  pitaya_pkg::offset_t sum_i,
  // output stream
  output pitaya_pkg::sample_t smp_o,
  output logic                vld_o
);

  // full product, shifted product, sum with one guard bit
  localparam int PRD_W = `SAMPLE_W + `GAIN_W;
  localparam int SHF_W = PRD_W - `GAIN_FRAC;
  localparam int ADD_W = SHF_W + 1;
  // output range
  localparam logic signed [ADD_W-1:0] SAT_MAX = ADD_W'(2**(`SAMPLE_W-1) - 1);
  localparam logic signed [ADD_W-1:0] SAT_MIN = -ADD_W'(2**(`SAMPLE_W-1));

  logic signed [PRD_W-1:0] prd_r;
  logic                    vld_r;
  logic signed [SHF_W-1:0] prd_shf;
  logic signed [ADD_W-1:0] add_full;
  pitaya_pkg::sample_t     sat_smp;

  // stage one, full width product
  always_ff @(posedge adc_clk) begin
    prd_r <= smp_i * mul_i;
  end

  // dropping the fraction bits is an arithmetic shift, rounds down
  assign prd_shf  = prd_r[PRD_W-1:`GAIN_FRAC];
  assign add_full = prd_shf + sum_i;

  // clamp to the sample range
  always_comb begin
    if (add_full > SAT_MAX) begin
      sat_smp = SAT_MAX[`SAMPLE_W-1:0];
    end else if (add_full < SAT_MIN) begin
      sat_smp = SAT_MIN[`SAMPLE_W-1:0];
    end else begin
      sat_smp = add_full[`SAMPLE_W-1:0];
    end
  end

  // stage two, result register
  always_ff @(posedge adc_clk) begin
    smp_o <= sat_smp;
  end

  // valid travels with the data
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_r <= 1'b0;
      vld_o <= 1'b0;
    end else begin
      vld_r <= vld_i;
      vld_o <= vld_r;
    end
  end

endmodule

// ==== design/adc_frontend.sv ====
// adc input side for all channels
// pin capture, signed conversion, digital loopback mux and calibration

`timescale 1ns/10ps
`include "pitaya_defines.svh"

module adc_frontend (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  // adc pins
  input  pitaya_pkg::adc_pin_t [`PITAYA_CHN-1:0] adc_dat_i,
  // calibrated dac samples for loopback
  input  pitaya_pkg::sample_t  [`PITAYA_CHN-1:0] loop_smp_i,
  input  logic                                  loop_vld_i,
  // settings
  calib_cfg_if.chan                             cfg,
  // calibrated adc stream
  output pitaya_pkg::sample_t  [`PITAYA_CHN-1:0] smp_o,
  output logic                                  vld_o
);

  pitaya_pkg::sample_t [`PITAYA_CHN-1:0] raw_smp;
  logic                                  raw_vld;
  pitaya_pkg::sample_t [`PITAYA_CHN-1:0] mux_smp;
  logic                                  mux_vld;
  logic                [`PITAYA_CHN-1:0] cal_vld;

  // pins deliver a sample every cycle once out of reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      raw_vld <= 1'b0;
    end else begin
      raw_vld <= 1'b1;
    end
  end

  // loopback valid follows the generator
  assign mux_vld = cfg.digital_loop ? loop_vld_i : raw_vld;

  //////////////////////////////////////////////////////////////////////
  // per channel data path
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `PITAYA_CHN; i++) begin : g_chn

    // upper 14 pin bits, msb kept and the rest inverted
    // lowest 2 pin bits unused
    always_ff @(posedge adc_clk) begin
      raw_smp[i] <= {adc_dat_i[i][`ADC_PIN_W-1],
                     ~adc_dat_i[i][`ADC_PIN_W-2:`ADC_PIN_W-`SAMPLE_W]};
    end

    // digital loopback mux
    assign mux_smp[i] = cfg.digital_loop ? loop_smp_i[i] : raw_smp[i];

    gain_offset u_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (mux_smp[i]),
      .vld_i   (mux_vld),
      .mul_i   (cfg.adc_mul[i]),
      .sum_i   (cfg.adc_sum[i]),
      .smp_o   (smp_o[i]),
      .vld_o   (cal_vld[i])
    );

  end

  // channels run in lock step
  assign vld_o = &cal_vld;

endmodule

// ==== design/dac_backend.sv ====
// dac output side for all channels
// generator calibration, loopback tap, dac code conversion and output registers

`timescale 1ns/10ps
`include "pitaya_defines.svh"

module dac_backend (
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  // generator stream
  input  pitaya_pkg::sample_t   [`PITAYA_CHN-1:0] gen_dat_i,
  input  logic                                   gen_vld_i,
  // settings
  calib_cfg_if.chan                              cfg,
  // dac outputs
  output pitaya_pkg::dac_code_t [`PITAYA_CHN-1:0] dac_dat_o,
  output logic                                   dac_vld_o,
  // calibrated samples toward the adc side
  output pitaya_pkg::sample_t   [`PITAYA_CHN-1:0] loop_smp_o,
  output logic                                   loop_vld_o
);

  logic [`PITAYA_CHN-1:0] cal_vld;

  //////////////////////////////////////////////////////////////////////
  // per channel data path
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `PITAYA_CHN; i++) begin : g_chn

    gain_offset u_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (gen_dat_i[i]),
      .vld_i   (gen_vld_i),
      .mul_i   (cfg.dac_mul[i]),
      .sum_i   (cfg.dac_sum[i]),
      .smp_o   (loop_smp_o[i]),
      .vld_o   (cal_vld[i])
    );

    // signed to offset binary, inverted for the negative slope
    // msb kept, the rest inverted
    always_ff @(posedge adc_clk) begin
      dac_dat_o[i] <= {loop_smp_o[i][`SAMPLE_W-1], ~loop_smp_o[i][`SAMPLE_W-2:0]};
    end

  end

  // channels run in lock step
  assign loop_vld_o = &cal_vld;

  // output valid, one cycle behind the calibrated sample
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_vld_o <= 1'b0;
    end else begin
      dac_vld_o <= loop_vld_o;
    end
  end

endmodule

// ==== design/pitaya_top.sv ====
// top level of the analog data path
// register block, adc input side and dac output side on plain ports

`timescale 1ns/10ps
`include "pitaya_defines.svh"

module pitaya_top (
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  // adc pins
  input  pitaya_pkg::adc_pin_t  [`PITAYA_CHN-1:0] adc_dat_i,
  // generator stream
  input  pitaya_pkg::sample_t   [`PITAYA_CHN-1:0] gen_dat_i,
  input  logic                                   gen_vld_i,
  // calibrated adc stream
  output pitaya_pkg::sample_t   [`PITAYA_CHN-1:0] adc_smp_o,
  output logic                                   adc_vld_o,
  // dac outputs, one port per channel
  output pitaya_pkg::dac_code_t [`PITAYA_CHN-1:0] dac_dat_o,
  output logic                                   dac_vld_o,
  // wishbone classic slave
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  pitaya_pkg::wb_adr_t                    wb_adr_i,
  input  pitaya_pkg::wb_dat_t                    wb_dat_i,
  output pitaya_pkg::wb_dat_t                    wb_dat_o,
  output logic                                   wb_ack_o
);

  // calibrated dac samples looped toward the adc side
  pitaya_pkg::sample_t [`PITAYA_CHN-1:0] loop_smp;
  logic                                  loop_vld;

  calib_cfg_if cfg ();

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  calib_regs u_regs (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .cfg      (cfg.regs)
  );

  //////////////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .loop_smp_i (loop_smp),
    .loop_vld_i (loop_vld),
    .cfg        (cfg.chan),
    .smp_o      (adc_smp_o),
    .vld_o      (adc_vld_o)
  );

  dac_backend u_dac (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .gen_dat_i  (gen_dat_i),
    .gen_vld_i  (gen_vld_i),
    .cfg        (cfg.chan),
    .dac_dat_o  (dac_dat_o),
    .dac_vld_o  (dac_vld_o),
    .loop_smp_o (loop_smp),
    .loop_vld_o (loop_vld)
  );

endmodule

// ==== testbench/tb_pitaya_tasks.svh ====
// testbench tasks for the analog data path
// wishbone access, waits with timeouts, compare tasks and directed tests

`ifndef TB_PITAYA_TASKS_SVH
`define TB_PITAYA_TASKS_SVH

////////////////////////////////////////////////////////////////////////
// failure handling and compares
////////////////////////////////////////////////////////////////////////

task automatic abort_run();
  $display("TESTS FAILED");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_sample(input pitaya_pkg::sample_t got, input pitaya_pkg::sample_t exp,
                            input string msg);
  if (got !== exp) begin
    $display("CHECK FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
    abort_run();
  end
endtask

task automatic check_code(input pitaya_pkg::dac_code_t got, input pitaya_pkg::dac_code_t exp,
                          input string msg);
  if (got !== exp) begin
    $display("CHECK FAILED at %0t ns: %s, got 0x%04h expected 0x%04h", $time, msg, got, exp);
    abort_run();
  end
endtask

task automatic check_word(input pitaya_pkg::wb_dat_t got, input pitaya_pkg::wb_dat_t exp,
                          input string msg);
  if (got !== exp) begin
    $display("CHECK FAILED at %0t ns: %s, got 0x%08h expected 0x%08h", $time, msg, got, exp);
    abort_run();
  end
endtask

task automatic expect_flag(input logic got, input logic exp, input string msg);
  if (got !== exp) begin
    $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
    abort_run();
  end
endtask

////////////////////////////////////////////////////////////////////////
// waits bounded by WAIT_MAX cycles
////////////////////////////////////////////////////////////////////////

task automatic await_ack();
  int   n;
  logic seen;
  n    = 0;
  seen = 1'b0;
  while (!seen && n < WAIT_MAX) begin
    @(negedge adc_clk);
    seen = wb_ack;
    n++;
  end
  if (!seen) begin
    $display("timeout at %0t ns: no wishbone ack within %0d cycles", $time, WAIT_MAX);
    abort_run();
  end
endtask

task automatic await_adc_valid();
  int   n;
  logic seen;
  n    = 0;
  seen = 1'b0;
  while (!seen && n < WAIT_MAX) begin
    @(negedge adc_clk);
    seen = adc_vld;
    n++;
  end
  if (!seen) begin
    $display("timeout at %0t ns: adc valid not seen within %0d cycles", $time, WAIT_MAX);
    abort_run();
  end
endtask

////////////////////////////////////////////////////////////////////////
// wishbone master
////////////////////////////////////////////////////////////////////////

// request still held on this edge, so a second ack would show here
task automatic release_bus();
  @(posedge adc_clk);
  wb_cyc <= 1'b0;
  wb_stb <= 1'b0;
  wb_we  <= 1'b0;
  @(negedge adc_clk);
  expect_flag(wb_ack, 1'b0, "wishbone ack longer than one cycle");
endtask

// request held until ack, then dropped on the next edge
task automatic bus_write(input pitaya_pkg::wb_adr_t adr, input pitaya_pkg::wb_dat_t dat);
  @(posedge adc_clk);
  wb_cyc  <= 1'b1;
  wb_stb  <= 1'b1;
  wb_we   <= 1'b1;
  wb_adr  <= adr;
  wb_wdat <= dat;
  await_ack();
  release_bus();
endtask

task automatic bus_read(input pitaya_pkg::wb_adr_t adr, output pitaya_pkg::wb_dat_t dat);
  @(posedge adc_clk);
  wb_cyc <= 1'b1;
  wb_stb <= 1'b1;
  wb_we  <= 1'b0;
  wb_adr <= adr;
  await_ack();
  // read data comes with ack
  dat = wb_rdat;
  release_bus();
endtask

// settings written through the bus and mirrored in the model
task automatic set_adc_cal(input int ch, input pitaya_pkg::gain_t mul,
                           input pitaya_pkg::offset_t sum);
  bus_write(pitaya_pkg::wb_adr_t'(`REG_ADC_MUL0 + 2*ch), pitaya_pkg::wb_dat_t'(mul));
  bus_write(pitaya_pkg::wb_adr_t'(`REG_ADC_SUM0 + 2*ch), pitaya_pkg::wb_dat_t'(sum));
  adc_mul_m[ch] = mul;
  adc_sum_m[ch] = sum;
endtask

task automatic set_dac_cal(input int ch, input pitaya_pkg::gain_t mul,
                           input pitaya_pkg::offset_t sum);
  bus_write(pitaya_pkg::wb_adr_t'(`REG_DAC_MUL0 + 2*ch), pitaya_pkg::wb_dat_t'(mul));
  bus_write(pitaya_pkg::wb_adr_t'(`REG_DAC_SUM0 + 2*ch), pitaya_pkg::wb_dat_t'(sum));
  dac_mul_m[ch] = mul;
  dac_sum_m[ch] = sum;
endtask

task automatic set_loopback(input logic on);
  bus_write(`REG_LOOP, pitaya_pkg::wb_dat_t'(on));
  loop_m = on;
endtask

////////////////////////////////////////////////////////////////////////
// streams
////////////////////////////////////////////////////////////////////////

// new random pins every cycle and the output checked 3 cycles later
task automatic adc_stream(input string tag);
  pitaya_pkg::adc_pin_t pins [0:STREAM_N-1][0:`PITAYA_CHN-1];
  pitaya_pkg::sample_t  exp;
  int                   c;
  int                   ch;
  for (c = 0; c < STREAM_N + ADC_LAT; c++) begin
    @(posedge adc_clk);
    if (c < STREAM_N) begin
      for (ch = 0; ch < `PITAYA_CHN; ch++) begin
        pins[c][ch] = pitaya_pkg::adc_pin_t'($random(seed));
        adc_dat[ch] <= pins[c][ch];
      end
    end
    @(negedge adc_clk);
    if (c >= ADC_LAT) begin
      expect_flag(adc_vld, 1'b1, {tag, ": adc valid"});
      for (ch = 0; ch < `PITAYA_CHN; ch++) begin
        exp = calib_ref(pin_to_sample(pins[c-ADC_LAT][ch]), adc_mul_m[ch], adc_sum_m[ch]);
        check_sample(adc_smp[ch], exp,
                     $sformatf("%s: adc channel %0d sample %0d", tag, ch, c - ADC_LAT));
      end
    end
  end
endtask

// random generator samples and valid with the dac side at 3 cycles
// adc side at 4 cycles when loopback is on
task automatic gen_stream(input string tag);
  pitaya_pkg::sample_t gen [0:STREAM_N-1][0:`PITAYA_CHN-1];
  logic                vld [0:STREAM_N-1];
  pitaya_pkg::sample_t cal;
  int                  rnd;
  int                  c;
  int                  ch;
  int                  k;
  for (c = 0; c < STREAM_N + LOOP_LAT; c++) begin
    @(posedge adc_clk);
    if (c < STREAM_N) begin
      rnd     = $random(seed);
      vld[c]  = rnd[0];
      gen_vld <= vld[c];
      for (ch = 0; ch < `PITAYA_CHN; ch++) begin
        gen[c][ch] = pitaya_pkg::sample_t'($random(seed));
        gen_dat[ch] <= gen[c][ch];
      end
    end else begin
      gen_vld <= 1'b0;
    end
    @(negedge adc_clk);
    k = c - DAC_LAT;
    if (k >= 0 && k < STREAM_N) begin
      expect_flag(dac_vld, vld[k], $sformatf("%s: dac valid %0d", tag, k));
      for (ch = 0; ch < `PITAYA_CHN; ch++) begin
        if (vld[k]) begin
          cal = calib_ref(gen[k][ch], dac_mul_m[ch], dac_sum_m[ch]);
          check_code(dac_dat[ch], sample_to_code(cal),
                     $sformatf("%s: dac channel %0d sample %0d", tag, ch, k));
        end
      end
    end
    k = c - LOOP_LAT;
    if (loop_m && k >= 0) begin
      expect_flag(adc_vld, vld[k], $sformatf("%s: looped adc valid %0d", tag, k));
      for (ch = 0; ch < `PITAYA_CHN; ch++) begin
        if (vld[k]) begin
          cal = calib_ref(gen[k][ch], dac_mul_m[ch], dac_sum_m[ch]);
          check_sample(adc_smp[ch], calib_ref(cal, adc_mul_m[ch], adc_sum_m[ch]),
                       $sformatf("%s: looped adc channel %0d sample %0d", tag, ch, k));
        end
      end
    end
  end
endtask

////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////

task automatic regs_readback();
  pitaya_pkg::wb_dat_t wr [0:ADR_N-1];
  pitaya_pkg::wb_dat_t rd;
  int                  a;
  int                  ch;
  // unity word has zero offset and flag bits, so it gives every reset value
  for (a = 0; a < ADR_N; a++) begin
    bus_read(pitaya_pkg::wb_adr_t'(a), rd);
    check_word(rd, readback_of(pitaya_pkg::wb_adr_t'(a), `GAIN_UNITY),
               $sformatf("reset value at address %0d", a));
  end
  // all addresses written first and read afterwards so aliasing shows up
  for (a = 0; a < ADR_N; a++) begin
    wr[a] = $random(seed);
    bus_write(pitaya_pkg::wb_adr_t'(a), wr[a]);
  end
  for (a = 0; a < ADR_N; a++) begin
    bus_read(pitaya_pkg::wb_adr_t'(a), rd);
    check_word(rd, readback_of(pitaya_pkg::wb_adr_t'(a), wr[a]),
               $sformatf("readback at address %0d", a));
  end
  // back to defaults for the data path tests
  for (ch = 0; ch < `PITAYA_CHN; ch++) begin
    set_adc_cal(ch, `GAIN_UNITY, '0);
    set_dac_cal(ch, `GAIN_UNITY, '0);
  end
  set_loopback(1'b0);
endtask

task automatic adc_unity_path();
  await_adc_valid();
  adc_stream("adc unity");
endtask

task automatic adc_calibration();
  pitaya_pkg::gain_t mul;
  int                r;
  int                ch;
  for (r = 0; r < 4; r++) begin
    for (ch = 0; ch < `PITAYA_CHN; ch++) begin
      // first two rounds near both gain limits saturate either way
      case (r)
        0:       mul = 16'h7fff;
        1:       mul = 16'h8000;
        default: mul = pitaya_pkg::gain_t'($random(seed));
      endcase
      set_adc_cal(ch, mul, pitaya_pkg::offset_t'($random(seed)));
    end
    adc_stream($sformatf("adc calibration round %0d", r));
  end
endtask

task automatic dac_path();
  int ch;
  for (ch = 0; ch < `PITAYA_CHN; ch++) begin
    set_dac_cal(ch, pitaya_pkg::gain_t'($random(seed)), pitaya_pkg::offset_t'($random(seed)));
  end
  gen_stream("dac path");
endtask

task automatic digital_loopback();
  int ch;
  for (ch = 0; ch < `PITAYA_CHN; ch++) begin
    set_adc_cal(ch, pitaya_pkg::gain_t'($random(seed)), pitaya_pkg::offset_t'($random(seed)));
    set_dac_cal(ch, pitaya_pkg::gain_t'($random(seed)), pitaya_pkg::offset_t'($random(seed)));
  end
  set_loopback(1'b1);
  gen_stream("loopback");
  // pins come back once the flag is cleared
  set_loopback(1'b0);
  adc_stream("loopback cleared");
endtask

`endif

// ==== testbench/tb_pitaya_top.sv ====
// testbench top for the analog data path
// clock, reset, DUT instance, reference model and test sequence

`timescale 1ns/10ps
`include "pitaya_defines.svh"

module tb_pitaya_top;

  // samples per stream, pipeline depths, wait limit in cycles
  localparam int STREAM_N = 32;
  localparam int ADC_LAT  = 3;
  localparam int DAC_LAT  = 3;
  localparam int LOOP_LAT = 4;
  localparam int WAIT_MAX = 20;
  localparam int ADR_N    = 1 << `WB_ADR_W;
  // sample range and the bits below the msb
  localparam longint SMP_MAX = (1 << (`SAMPLE_W-1)) - 1;
  localparam longint SMP_MIN = -(1 << (`SAMPLE_W-1));
  localparam logic [`SAMPLE_W-1:0] LOW_MASK = {1'b0, {(`SAMPLE_W-1){1'b1}}};

  logic                                   adc_clk;
  logic                                   top_rst;
  pitaya_pkg::adc_pin_t  [`PITAYA_CHN-1:0] adc_dat;
  pitaya_pkg::sample_t   [`PITAYA_CHN-1:0] gen_dat;
  logic                                   gen_vld;
  pitaya_pkg::sample_t   [`PITAYA_CHN-1:0] adc_smp;
  logic                                   adc_vld;
  pitaya_pkg::dac_code_t [`PITAYA_CHN-1:0] dac_dat;
  logic                                   dac_vld;
  logic                                   wb_cyc;
  logic                                   wb_stb;
  logic                                   wb_we;
  pitaya_pkg::wb_adr_t                    wb_adr;
  pitaya_pkg::wb_dat_t                    wb_wdat;
  pitaya_pkg::wb_dat_t                    wb_rdat;
  logic                                   wb_ack;

  // model copy of the calibration settings
  pitaya_pkg::gain_t   adc_mul_m [0:`PITAYA_CHN-1];
  pitaya_pkg::offset_t adc_sum_m [0:`PITAYA_CHN-1];
  pitaya_pkg::gain_t   dac_mul_m [0:`PITAYA_CHN-1];
  pitaya_pkg::offset_t dac_sum_m [0:`PITAYA_CHN-1];
  logic                loop_m;
  integer              seed;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // multiply, arithmetic shift (rounds down), add offset, clamp
  function automatic pitaya_pkg::sample_t calib_ref(input pitaya_pkg::sample_t smp,
                                                    input pitaya_pkg::gain_t mul,
                                                    input pitaya_pkg::offset_t sum);
    longint acc;
    acc = longint'(smp) * longint'(mul);
    acc = acc >>> `GAIN_FRAC;
    acc = acc + longint'(sum);
    if (acc > SMP_MAX) begin
      acc = SMP_MAX;
    end else if (acc < SMP_MIN) begin
      acc = SMP_MIN;
    end
    return pitaya_pkg::sample_t'(acc);
  endfunction

  // upper pin bits, everything below the msb flipped
  function automatic pitaya_pkg::sample_t pin_to_sample(input pitaya_pkg::adc_pin_t pin);
    return pitaya_pkg::sample_t'(pin[`ADC_PIN_W-1 -: `SAMPLE_W] ^ LOW_MASK);
  endfunction

  // inverted offset binary
  function automatic pitaya_pkg::dac_code_t sample_to_code(input pitaya_pkg::sample_t smp);
    return pitaya_pkg::dac_code_t'(smp ^ LOW_MASK);
  endfunction

  // expected register readback after writing word w
  function automatic pitaya_pkg::wb_dat_t readback_of(input pitaya_pkg::wb_adr_t adr,
                                                      input pitaya_pkg::wb_dat_t w);
    pitaya_pkg::wb_dat_t r;
    case (adr)
      `REG_LOOP:
        r = pitaya_pkg::wb_dat_t'(w[0]);
      `REG_ADC_MUL0, `REG_ADC_MUL1, `REG_DAC_MUL0, `REG_DAC_MUL1:
        r = {{(`WB_DAT_W-`GAIN_W){w[`GAIN_W-1]}}, w[`GAIN_W-1:0]};
      `REG_ADC_SUM0, `REG_ADC_SUM1, `REG_DAC_SUM0, `REG_DAC_SUM1:
        r = {{(`WB_DAT_W-`SAMPLE_W){w[`SAMPLE_W-1]}}, w[`SAMPLE_W-1:0]};
      default:
        r = '0;
    endcase
    return r;
  endfunction

  `include "tb_pitaya_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // DUT
  //////////////////////////////////////////////////////////////////////

  pitaya_top UUT (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .gen_dat_i (gen_dat),
    .gen_vld_i (gen_vld),
    .adc_smp_o (adc_smp),
    .adc_vld_o (adc_vld),
    .dac_dat_o (dac_dat),
    .dac_vld_o (dac_vld),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_wdat),
    .wb_dat_o  (wb_rdat),
    .wb_ack_o  (wb_ack)
  );

  // 8 ns clock
  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  // test sequence
  initial begin
    seed    = 32'hef224d73;
    top_rst = 1'b1;
    adc_dat = '0;
    gen_dat = '0;
    gen_vld = 1'b0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    loop_m  = 1'b0;
    for (int ch = 0; ch < `PITAYA_CHN; ch++) begin
      adc_mul_m[ch] = `GAIN_UNITY;
      adc_sum_m[ch] = '0;
      dac_mul_m[ch] = `GAIN_UNITY;
      dac_sum_m[ch] = '0;
    end
    // outputs quiet while reset is held
    repeat (9) @(posedge adc_clk);
    @(negedge adc_clk);
    expect_flag(adc_vld, 1'b0, "adc valid in reset");
    expect_flag(dac_vld, 1'b0, "dac valid in reset");
    expect_flag(wb_ack, 1'b0, "wishbone ack in reset");
    @(posedge adc_clk);
    top_rst <= 1'b0;
    regs_readback();
    adc_unity_path();
    adc_calibration();
    dac_path();
    digital_loopback();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+design
+incdir+testbench
design/pitaya_pkg.sv
design/calib_cfg_if.sv
design/calib_regs.sv
design/gain_offset.sv
design/adc_frontend.sv
design/dac_backend.sv
design/pitaya_top.sv
testbench/tb_pitaya_top.sv
